/* common/core_isa_pkg.sv */
`default_nettype none

package core_isa_pkg;

    localparam int xlen          = 32;
    localparam int reg_idx_width = 5;

    // Major opcodes of the supported subset
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;

    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_xor     = 3'b100;
    localparam logic [2:0] funct3_or      = 3'b110;
    localparam logic [2:0] funct3_and     = 3'b111;
    localparam logic [2:0] funct3_mul     = 3'b000;
    // LW and SW
    localparam logic [2:0] funct3_word    = 3'b010;

    localparam logic [6:0] funct7_base   = 7'b0000000;
    localparam logic [6:0] funct7_sub    = 7'b0100000;
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

endpackage

`default_nettype wire

/* common/core_uarch_pkg.sv */
`default_nettype none

package core_uarch_pkg;

    localparam int rob_depth     = 8;
    localparam int rob_tag_width = 3;
    localparam int mul_stages    = 3;

    typedef logic [rob_tag_width-1:0] rob_tag_t;

    // Word bus shared by fetch and load/store
    typedef struct packed {
        logic                            read;
        logic                            write;
        logic [core_isa_pkg::xlen-1:0]   addr;
        logic [core_isa_pkg::xlen-1:0]   wdata;
    } mem_req_t;

    typedef struct packed {
        logic                            ready;
        logic [core_isa_pkg::xlen-1:0]   rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic                                  valid;
        logic [core_isa_pkg::xlen-1:0]         pc;
        logic [core_isa_pkg::reg_idx_width-1:0] rd;
        logic                                  is_store;
    } alloc_t;

    typedef struct packed {
        logic                            valid;
        rob_tag_t                        tag;
        logic [core_isa_pkg::xlen-1:0]   value;
    } complete_t;

    typedef struct packed {
        logic                            valid;
        logic                            is_store;
        logic [core_isa_pkg::xlen-1:0]   addr;
        logic [core_isa_pkg::xlen-1:0]   wdata;
        rob_tag_t                        tag;
    } lsu_op_t;

    typedef struct packed {
        logic                            valid;
        logic [core_isa_pkg::xlen-1:0]   a;
        logic [core_isa_pkg::xlen-1:0]   b;
        rob_tag_t                        tag;
    } mul_op_t;

    typedef struct packed {
        logic                                  valid;
        logic [core_isa_pkg::xlen-1:0]         pc;
        logic [core_isa_pkg::reg_idx_width-1:0] rd;
        logic [core_isa_pkg::xlen-1:0]         value;
    } commit_t;

    typedef struct packed {
        logic [core_isa_pkg::reg_idx_width-1:0] rs;
    } bypass_query_t;

    typedef struct packed {
        logic                            hit;
        logic                            pending;
        logic [core_isa_pkg::xlen-1:0]   value;
    } bypass_result_t;

endpackage

`default_nettype wire

/* hdl/fetch_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_unit (
    input  wire                              clk,
    input  wire                              reset,
    output core_uarch_pkg::mem_req_t         mem_req,
    input  wire core_uarch_pkg::mem_rsp_t    mem_rsp,
    input  wire                              instr_take,
    output logic                             instr_valid,
    output logic [core_isa_pkg::xlen-1:0]    instr,
    output logic [core_isa_pkg::xlen-1:0]    pc
);

    logic [core_isa_pkg::xlen-1:0] pc_q;
    logic                          fetch_en;
    logic                          fill;

    // Read at the program counter whenever the buffer is empty
    always_comb begin
        mem_req.read  = fetch_en && !instr_valid;
        mem_req.write = 1'b0;
        mem_req.addr  = pc_q;
        mem_req.wdata = '0;
    end

    assign fill = mem_req.read && mem_rsp.ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q        <= '0;
            fetch_en    <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (fill) begin
                instr_valid <= 1'b1;
                pc_q        <= pc_q + 32'd4;
            end else if (instr_take) begin
                instr_valid <= 1'b0;
            end
        end
    end

    // Holding buffer
    always_ff @(posedge clk) begin
        if (fill) begin
            instr <= mem_rsp.rdata;
            pc    <= pc_q;
        end
    end

endmodule

`default_nettype wire

/* hdl/mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
    input  wire                              clk,
    input  wire                              reset,
    input  wire core_uarch_pkg::mem_req_t    lsu_req,
    output core_uarch_pkg::mem_rsp_t         lsu_rsp,
    input  wire core_uarch_pkg::mem_req_t    fetch_req,
    output core_uarch_pkg::mem_rsp_t         fetch_rsp,
    output core_uarch_pkg::mem_req_t         mem_req,
    input  wire core_uarch_pkg::mem_rsp_t    mem_rsp
);

    logic locked;
    logic owner_lsu;
    logic grant_lsu;

    // Owner stays fixed while its request waits for ready
    assign grant_lsu = locked ? owner_lsu : (lsu_req.read || lsu_req.write);

    always_comb begin
        mem_req         = grant_lsu ? lsu_req : fetch_req;
        lsu_rsp.ready   = mem_rsp.ready && grant_lsu;
        lsu_rsp.rdata   = grant_lsu ? mem_rsp.rdata : '0;
        fetch_rsp.ready = mem_rsp.ready && !grant_lsu;
        fetch_rsp.rdata = grant_lsu ? '0 : mem_rsp.rdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            locked    <= 1'b0;
            owner_lsu <= 1'b0;
        end else begin
            locked    <= (mem_req.read || mem_req.write) && !mem_rsp.ready;
            owner_lsu <= grant_lsu;
        end
    end

endmodule

`default_nettype wire

/* hdl/decode_issue.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_issue (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire                                   instr_valid,
    input  wire [core_isa_pkg::xlen-1:0]          instr,
    input  wire [core_isa_pkg::xlen-1:0]          pc,
    output logic                                  instr_take,
    output core_uarch_pkg::alloc_t                alloc,
    input  wire core_uarch_pkg::rob_tag_t         alloc_tag,
    input  wire                                   rob_full,
    output core_uarch_pkg::bypass_query_t         query_a,
    output core_uarch_pkg::bypass_query_t         query_b,
    input  wire core_uarch_pkg::bypass_result_t   result_a,
    input  wire core_uarch_pkg::bypass_result_t   result_b,
    input  wire core_uarch_pkg::commit_t          commit,
    input  wire                                   lsu_busy,
    output core_uarch_pkg::mul_op_t               mul_op,
    output core_uarch_pkg::lsu_op_t               lsu_op,
    output core_uarch_pkg::complete_t             alu_done
);

    logic [core_isa_pkg::xlen-1:0] regs [2**core_isa_pkg::reg_idx_width];
    logic [6:0] opcode, funct7;
    logic [2:0] funct3;
    logic [core_isa_pkg::reg_idx_width-1:0] rs1, rs2, dest;
    logic [core_isa_pkg::xlen-1:0] imm_i, imm_s, op_a, op_b, alu_b, alu_result;
    logic is_alu, is_mul, is_load, is_store, is_sub, use_rs1, use_rs2, use_imm;
    logic issue;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    // Anything outside the subset falls through as ADDI x0
    always_comb begin
        {is_alu, is_mul, is_load, is_store} = 4'b1000;
        {is_sub, use_rs1, use_rs2, use_imm} = 4'b0000;
        dest = '0;
        case (opcode)
            core_isa_pkg::opcode_op: begin
                if (funct7 == core_isa_pkg::funct7_muldiv
                        && funct3 == core_isa_pkg::funct3_mul) begin
                    {is_alu, is_mul, use_rs1, use_rs2} = 4'b0111;
                    dest = instr[11:7];
                end else if ((funct7 == core_isa_pkg::funct7_base
                            && funct3 inside {core_isa_pkg::funct3_add_sub,
                                core_isa_pkg::funct3_xor, core_isa_pkg::funct3_or,
                                core_isa_pkg::funct3_and})
                        || (funct7 == core_isa_pkg::funct7_sub
                            && funct3 == core_isa_pkg::funct3_add_sub)) begin
                    {use_rs1, use_rs2} = 2'b11;
                    is_sub = (funct7 == core_isa_pkg::funct7_sub);
                    dest = instr[11:7];
                end
            end
            core_isa_pkg::opcode_op_imm: begin
                if (funct3 == core_isa_pkg::funct3_add_sub) begin
                    {use_rs1, use_imm} = 2'b11;
                    dest = instr[11:7];
                end
            end
            core_isa_pkg::opcode_load: begin
                if (funct3 == core_isa_pkg::funct3_word) begin
                    {is_alu, is_load, use_rs1} = 3'b011;
                    dest = instr[11:7];
                end
            end
            core_isa_pkg::opcode_store: begin
                if (funct3 == core_isa_pkg::funct3_word) begin
                    {is_alu, is_store, use_rs1, use_rs2} = 4'b0111;
                end
            end
            default: ;
        endcase
    end

    // Operands come from the ROB when a writer is in flight
    assign query_a.rs = use_rs1 ? rs1 : '0;
    assign query_b.rs = use_rs2 ? rs2 : '0;
    assign op_a = (query_a.rs == '0) ? '0 : result_a.hit ? result_a.value : regs[query_a.rs];
    assign op_b = (query_b.rs == '0) ? '0 : result_b.hit ? result_b.value : regs[query_b.rs];

    assign issue = instr_valid && !rob_full && !result_a.pending && !result_b.pending
                   && !((is_load || is_store) && lsu_busy);
    assign instr_take = issue;

    always_comb begin
        alloc.valid    = issue;
        alloc.pc       = pc;
        alloc.rd       = dest;
        alloc.is_store = is_store;
    end

    assign alu_b = use_imm ? imm_i : op_b;
    always_comb begin
        case (funct3)
            core_isa_pkg::funct3_xor: alu_result = op_a ^ alu_b;
            core_isa_pkg::funct3_or:  alu_result = op_a | alu_b;
            core_isa_pkg::funct3_and: alu_result = op_a & alu_b;
            default:                  alu_result = is_sub ? op_a - alu_b : op_a + alu_b;
        endcase
    end

    assign mul_op = '{valid: issue && is_mul, a: op_a, b: op_b, tag: alloc_tag};
    assign lsu_op = '{valid: issue && (is_load || is_store), is_store: is_store,
                      addr: op_a + (is_store ? imm_s : imm_i), wdata: op_b, tag: alloc_tag};

    always_ff @(posedge clk) begin
        alu_done.tag   <= alloc_tag;
        alu_done.value <= alu_result;
        if (reset) begin
            alu_done.valid <= 1'b0;
        end else begin
            alu_done.valid <= issue && is_alu;
        end
    end

    // Architectural registers start at zero and are written only at commit
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 2**core_isa_pkg::reg_idx_width; r++) begin
                regs[r] <= '0;
            end
        end else if (commit.valid && commit.rd != '0) begin
            regs[commit.rd] <= commit.value;
        end
    end

endmodule

`default_nettype wire

/* hdl/mul_pipe.sv */
`timescale 1ns/10ps
`default_nettype none

module mul_pipe (
    input  wire                              clk,
    input  wire                              reset,
    input  wire core_uarch_pkg::mul_op_t     mul_op,
    output core_uarch_pkg::complete_t        mul_done
);

    core_uarch_pkg::complete_t stage_q [core_uarch_pkg::mul_stages];

    always_ff @(posedge clk) begin
        // Low word of the product enters the first stage
        stage_q[0].tag   <= mul_op.tag;
        stage_q[0].value <= mul_op.a * mul_op.b;
        for (int s = 1; s < core_uarch_pkg::mul_stages; s++) begin
            stage_q[s].tag   <= stage_q[s-1].tag;
            stage_q[s].value <= stage_q[s-1].value;
        end
        if (reset) begin
            for (int s = 0; s < core_uarch_pkg::mul_stages; s++) begin
                stage_q[s].valid <= 1'b0;
            end
        end else begin
            stage_q[0].valid <= mul_op.valid;
            for (int s = 1; s < core_uarch_pkg::mul_stages; s++) begin
                stage_q[s].valid <= stage_q[s-1].valid;
            end
        end
    end

    assign mul_done = stage_q[core_uarch_pkg::mul_stages-1];

endmodule

`default_nettype wire

/* hdl/load_store_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module load_store_unit (
    input  wire                              clk,
    input  wire                              reset,
    input  wire core_uarch_pkg::lsu_op_t     lsu_op,
    output logic                             lsu_busy,
    output core_uarch_pkg::mem_req_t         mem_req,
    input  wire core_uarch_pkg::mem_rsp_t    mem_rsp,
    output core_uarch_pkg::complete_t        lsu_done
);

    core_uarch_pkg::lsu_op_t op_q;
    logic                    finish;

    // Valid of the latched op doubles as the busy flag
    assign lsu_busy = op_q.valid;
    assign finish   = op_q.valid && mem_rsp.ready;

    always_comb begin
        mem_req.read  = op_q.valid && !op_q.is_store;
        mem_req.write = op_q.valid && op_q.is_store;
        mem_req.addr  = op_q.addr;
        mem_req.wdata = op_q.wdata;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            op_q.valid <= 1'b0;
        end else if (!op_q.valid && lsu_op.valid) begin
            op_q <= lsu_op;
        end else if (finish) begin
            op_q.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        lsu_done.tag   <= op_q.tag;
        lsu_done.value <= op_q.is_store ? '0 : mem_rsp.rdata;
        if (reset) begin
            lsu_done.valid <= 1'b0;
        end else begin
            lsu_done.valid <= finish;
        end
    end

endmodule

`default_nettype wire

/* rob/reorder_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module reorder_buffer (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire core_uarch_pkg::alloc_t           alloc,
    output core_uarch_pkg::rob_tag_t              alloc_tag,
    output logic                                  rob_full,
    input  wire core_uarch_pkg::complete_t        alu_done,
    input  wire core_uarch_pkg::complete_t        mul_done,
    input  wire core_uarch_pkg::complete_t        lsu_done,
    input  wire core_uarch_pkg::bypass_query_t    query_a,
    input  wire core_uarch_pkg::bypass_query_t    query_b,
    output core_uarch_pkg::bypass_result_t        result_a,
    output core_uarch_pkg::bypass_result_t        result_b,
    output core_uarch_pkg::commit_t               commit
);

    typedef logic [core_uarch_pkg::rob_tag_width:0] count_t;

    logic [core_isa_pkg::xlen-1:0]          pc_q    [core_uarch_pkg::rob_depth];
    logic [core_isa_pkg::reg_idx_width-1:0] rd_q    [core_uarch_pkg::rob_depth];
    logic [core_isa_pkg::xlen-1:0]          value_q [core_uarch_pkg::rob_depth];
    logic [core_uarch_pkg::rob_depth-1:0]   store_q;
    logic [core_uarch_pkg::rob_depth-1:0]   done_q;
    core_uarch_pkg::rob_tag_t               head, tail;
    count_t                                 count;
    logic                                   retire;

    assign alloc_tag = tail;
    assign rob_full  = (count == count_t'(core_uarch_pkg::rob_depth));

    // Head retires once done, one entry per cycle
    always_comb begin
        commit.valid = (count != '0) && done_q[head];
        commit.pc    = pc_q[head];
        commit.rd    = rd_q[head];
        commit.value = (store_q[head] || rd_q[head] == '0) ? '0 : value_q[head];
    end
    assign retire = commit.valid;

    // Walk oldest to youngest so the last match is the youngest writer
    always_comb begin
        core_uarch_pkg::rob_tag_t idx;
        result_a = '0;
        result_b = '0;
        for (int i = 0; i < core_uarch_pkg::rob_depth; i++) begin
            idx = head + core_uarch_pkg::rob_tag_t'(i);
            if (count_t'(i) < count && rd_q[idx] != '0) begin
                if (rd_q[idx] == query_a.rs) begin
                    result_a = '{hit: done_q[idx], pending: !done_q[idx], value: value_q[idx]};
                end
                if (rd_q[idx] == query_b.rs) begin
                    result_b = '{hit: done_q[idx], pending: !done_q[idx], value: value_q[idx]};
                end
            end
        end
    end

    // Entry payload and the three completion write ports
    always_ff @(posedge clk) begin
        if (alloc.valid) begin
            pc_q[tail]    <= alloc.pc;
            rd_q[tail]    <= alloc.rd;
            store_q[tail] <= alloc.is_store;
        end
        if (alu_done.valid) value_q[alu_done.tag] <= alu_done.value;
        if (mul_done.valid) value_q[mul_done.tag] <= mul_done.value;
        if (lsu_done.valid) value_q[lsu_done.tag] <= lsu_done.value;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head   <= '0;
            tail   <= '0;
            count  <= '0;
            done_q <= '0;
        end else begin
            if (alloc.valid) begin
                done_q[tail] <= 1'b0;
                tail         <= tail + 1'b1;
            end
            if (alu_done.valid) done_q[alu_done.tag] <= 1'b1;
            if (mul_done.valid) done_q[mul_done.tag] <= 1'b1;
            if (lsu_done.valid) done_q[lsu_done.tag] <= 1'b1;
            if (retire) head <= head + 1'b1;
            count <= count + count_t'(alloc.valid) - count_t'(retire);
        end
    end

endmodule

`default_nettype wire

/* hdl/core.sv */
`timescale 1ns/10ps
`default_nettype none

module core (
    input  wire                              clk,
    input  wire                              reset,
    output core_uarch_pkg::mem_req_t         mem_req,
    input  wire core_uarch_pkg::mem_rsp_t    mem_rsp,
    output core_uarch_pkg::commit_t          commit
);

    core_uarch_pkg::mem_req_t       fetch_req, lsu_req;
    core_uarch_pkg::mem_rsp_t       fetch_rsp, lsu_rsp;
    logic                           instr_valid, instr_take;
    logic [core_isa_pkg::xlen-1:0]  instr, instr_pc;
    core_uarch_pkg::alloc_t         alloc;
    core_uarch_pkg::rob_tag_t       alloc_tag;
    logic                           rob_full, lsu_busy;
    core_uarch_pkg::bypass_query_t  query_a, query_b;
    core_uarch_pkg::bypass_result_t result_a, result_b;
    core_uarch_pkg::mul_op_t        mul_op;
    core_uarch_pkg::lsu_op_t        lsu_op;
    core_uarch_pkg::complete_t      alu_done, mul_done, lsu_done;

    fetch_unit fetch_unit_inst (
        .clk, .reset,
        .mem_req(fetch_req), .mem_rsp(fetch_rsp),
        .instr_take, .instr_valid, .instr, .pc(instr_pc)
    );

    mem_arbiter mem_arbiter_inst (
        .clk, .reset,
        .lsu_req, .lsu_rsp, .fetch_req, .fetch_rsp,
        .mem_req, .mem_rsp
    );

    decode_issue decode_issue_inst (
        .clk, .reset,
        .instr_valid, .instr, .pc(instr_pc), .instr_take,
        .alloc, .alloc_tag, .rob_full,
        .query_a, .query_b, .result_a, .result_b,
        .commit, .lsu_busy, .mul_op, .lsu_op, .alu_done
    );

    mul_pipe mul_pipe_inst (
        .clk, .reset, .mul_op, .mul_done
    );

    load_store_unit load_store_unit_inst (
        .clk, .reset, .lsu_op, .lsu_busy,
        .mem_req(lsu_req), .mem_rsp(lsu_rsp), .lsu_done
    );

    reorder_buffer reorder_buffer_inst (
        .clk, .reset,
        .alloc, .alloc_tag, .rob_full,
        .alu_done, .mul_done, .lsu_done,
        .query_a, .query_b, .result_a, .result_b,
        .commit
    );

endmodule

`default_nettype wire

/* dv/core_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

module core_asserts (
    input wire                            clk,
    input wire                            reset,
    input wire core_uarch_pkg::mem_req_t  mem_req,
    input wire core_uarch_pkg::mem_rsp_t  mem_rsp,
    input wire core_uarch_pkg::commit_t   commit
);

    logic [core_isa_pkg::xlen-1:0] next_pc;

    // Pc expected at the next retirement
    always_ff @(posedge clk) begin
        if (reset) begin
            next_pc <= '0;
        end else if (commit.valid) begin
            next_pc <= commit.pc + 32'd4;
        end
    end

    bus_one_direction: assert property (@(posedge clk) disable iff (reset)
        !(mem_req.read && mem_req.write))
        else $error("mem_req has read and write high together");

    bus_request_held: assert property (@(posedge clk) disable iff (reset)
        ((mem_req.read || mem_req.write) && !mem_rsp.ready) |=> $stable(mem_req))
        else $error("mem_req changed while waiting for ready");

    commit_in_order: assert property (@(posedge clk) disable iff (reset)
        commit.valid |-> (commit.pc == next_pc))
        else $error("commit pc 0x%08h, next in order is 0x%08h", commit.pc, next_pc);

endmodule

bind core core_asserts core_asserts_inst (.clk, .reset, .mem_req, .mem_rsp, .commit);

`default_nettype wire

/* dv/tb_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_core;

    localparam int prog_len    = 200;
    localparam int mem_words   = 512;
    localparam int data_base   = 256;
    localparam int cycle_limit = 400;

    logic                     clk;
    logic                     reset;
    core_uarch_pkg::mem_req_t mem_req;
    core_uarch_pkg::mem_rsp_t mem_rsp;
    core_uarch_pkg::commit_t  commit;

    logic [31:0] mem [mem_words];
    logic [31:0] dmem_model [mem_words];
    logic [31:0] regs_model [32];
    logic [31:0] exp_value [prog_len];
    logic [4:0]  exp_rd [prog_len];
    logic [31:0] store_addr [$];
    logic [31:0] store_data [$];
    int          wait_left;

    core core_inst (.clk, .reset, .mem_req, .mem_rsp, .commit);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3,
                                           logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, core_isa_pkg::opcode_op};
    endfunction

    function automatic logic [31:0] i_type(logic [6:0] opcode, logic [2:0] f3,
                                           logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, opcode};
    endfunction

    // Store word with base x0
    function automatic logic [31:0] s_type(logic [4:0] rs2, logic [11:0] imm);
        return {imm[11:5], rs2, 5'd0, core_isa_pkg::funct3_word, imm[4:0],
                core_isa_pkg::opcode_store};
    endfunction

    function automatic logic [31:0] fill_word(int idx);
        return (32'(idx) * 32'h9e37_79b1) ^ 32'h0f1e_2d3c;
    endfunction

    task automatic end_in_failure();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, expected);
            end_in_failure();
        end
    endtask

    // Random program and the sequential ISA model that predicts every commit
    task automatic build_program();
        int          kind;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] imm, off;
        logic [31:0] a, b, result;
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = (i < data_base) ? i_type(core_isa_pkg::opcode_op_imm,
                core_isa_pkg::funct3_add_sub, 5'd0, 5'd0, 12'd0) : fill_word(i);
            dmem_model[i] = mem[i];
        end
        for (int r = 0; r < 32; r++) begin
            regs_model[r] = '0;
        end
        for (int i = 0; i < prog_len; i++) begin
            kind = $urandom_range(8, 0);
            rd   = 5'($urandom_range(7, 0));
            rs1  = 5'($urandom_range(7, 0));
            rs2  = 5'($urandom_range(7, 0));
            imm  = 12'($urandom);
            off  = 12'h400 + 12'(4 * $urandom_range(15, 0));
            a    = regs_model[rs1];
            b    = regs_model[rs2];
            case (kind)
                0: mem[i] = r_type(core_isa_pkg::funct7_base, core_isa_pkg::funct3_add_sub,
                                   rd, rs1, rs2);
                1: mem[i] = r_type(core_isa_pkg::funct7_sub, core_isa_pkg::funct3_add_sub,
                                   rd, rs1, rs2);
                2: mem[i] = r_type(core_isa_pkg::funct7_base, core_isa_pkg::funct3_and,
                                   rd, rs1, rs2);
                3: mem[i] = r_type(core_isa_pkg::funct7_base, core_isa_pkg::funct3_or,
                                   rd, rs1, rs2);
                4: mem[i] = r_type(core_isa_pkg::funct7_base, core_isa_pkg::funct3_xor,
                                   rd, rs1, rs2);
                5: mem[i] = i_type(core_isa_pkg::opcode_op_imm, core_isa_pkg::funct3_add_sub,
                                   rd, rs1, imm);
                6: mem[i] = r_type(core_isa_pkg::funct7_muldiv, core_isa_pkg::funct3_mul,
                                   rd, rs1, rs2);
                7: mem[i] = i_type(core_isa_pkg::opcode_load, core_isa_pkg::funct3_word,
                                   rd, 5'd0, off);
                default: mem[i] = s_type(rs2, off);
            endcase
            case (kind)
                0: result = a + b;
                1: result = a - b;
                2: result = a & b;
                3: result = a | b;
                4: result = a ^ b;
                5: result = a + {{20{imm[11]}}, imm};
                6: result = a * b;
                7: result = dmem_model[off[10:2]];
                default: result = '0;
            endcase
            if (kind == 8) begin
                store_addr.push_back({20'd0, off});
                store_data.push_back(b);
                dmem_model[off[10:2]] = b;
                rd = 5'd0;
            end
            if (rd != 5'd0) begin
                regs_model[rd] = result;
            end
            exp_rd[i]    = rd;
            exp_value[i] = (rd == 5'd0) ? 32'd0 : result;
        end
    endtask

    // Stores must appear on the bus in program order
    task automatic serve_request();
        if (mem_req.write) begin
            if (store_addr.size() == 0) begin
                $display("Store to 0x%08h that the program does not contain", mem_req.addr);
                end_in_failure();
            end else begin
                check_value("mem_req.addr", mem_req.addr, store_addr.pop_front());
                check_value("mem_req.wdata", mem_req.wdata, store_data.pop_front());
                mem[mem_req.addr[10:2]] = mem_req.wdata;
            end
        end
    endtask

    // Memory answers each request after 0 to 3 idle cycles
    always @(posedge clk) begin
        if (reset) begin
            mem_rsp   <= '0;
            wait_left = -1;
        end else if (mem_rsp.ready) begin
            mem_rsp.ready <= 1'b0;
            wait_left = -1;
        end else if (mem_req.read || mem_req.write) begin
            if (wait_left < 0) begin
                wait_left = $urandom_range(3, 0);
            end
            if (wait_left == 0) begin
                serve_request();
                mem_rsp.ready <= 1'b1;
                mem_rsp.rdata <= mem[mem_req.addr[10:2]];
            end else begin
                wait_left--;
            end
        end
    end

    task automatic wait_first_fetch();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            check_value("commit.valid", 32'(commit.valid), 32'd0);
            if (cycles > 50) begin
                $display("Timeout waiting for the first fetch after reset");
                end_in_failure();
            end
        end while (!(mem_req.read || mem_req.write));
        check_value("mem_req.read", 32'(mem_req.read), 32'd1);
        check_value("mem_req.write", 32'(mem_req.write), 32'd0);
        check_value("mem_req.addr", mem_req.addr, 32'd0);
    endtask

    initial begin
        int n;
        int cycles;
        reset   = 1'b1;
        mem_rsp = '0;
        void'($urandom(32'hde4b5dbd));
        build_program();
        // Bus and commit stay quiet once the first reset edge has passed
        for (int c = 0; c < 16; c++) begin
            @(posedge clk);
            if (c > 0) begin
                check_value("mem_req.read", 32'(mem_req.read), 32'd0);
                check_value("mem_req.write", 32'(mem_req.write), 32'd0);
                check_value("commit.valid", 32'(commit.valid), 32'd0);
            end
        end
        reset <= 1'b0;
        wait_first_fetch();
        n      = 0;
        cycles = 0;
        while (n < prog_len) begin
            @(posedge clk);
            cycles++;
            if (commit.valid) begin
                check_value("commit.pc", commit.pc, 32'(4 * n));
                check_value("commit.rd", 32'(commit.rd), 32'(exp_rd[n]));
                check_value("commit.value", commit.value, exp_value[n]);
                n++;
                cycles = 0;
            end else if (cycles > cycle_limit) begin
                $display("Timeout waiting for commit number %0d", n);
                end_in_failure();
            end
        end
        // Every store of the program has to reach the bus
        if (store_addr.size() != 0) begin
            $display("%0d stores of the program never reached the bus", store_addr.size());
            end_in_failure();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* tb.f */
common/core_isa_pkg.sv
common/core_uarch_pkg.sv
hdl/fetch_unit.sv
hdl/mem_arbiter.sv
hdl/decode_issue.sv
hdl/mul_pipe.sv
hdl/load_store_unit.sv
rob/reorder_buffer.sv
hdl/core.sv
dv/core_asserts.sv
dv/tb_core.sv

/* run.sh */
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and search the log for the pass line
set -u
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_core -f tb.f -o vtb_core \
    && ./obj_dir/vtb_core | tee sim.log \
    || { echo "Build or simulation failed"; exit 1; }

grep -qx "Done: no errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
